//--- source/mem_sys_consts.svh
`ifndef MEM_SYS_CONSTS_SVH
`define MEM_SYS_CONSTS_SVH

// Host bus widths
`define BUS_ADDR_W 32
`define BUS_DATA_W 32
`define BUS_STRB_W 4
`define LED_W 7

// Region code sits in the top two address bits
`define REGION_HI 31
`define REGION_LO 30

// Word-address widths of the two memories
`define MAIN_ADDR_W 12
`define DDR_ADDR_W 10

// Cycles from first valid to ready
`define MAIN_LATENCY 1
`define DDR_LATENCY 4

`endif

//--- source/mem_sys_pkg.sv
`default_nettype none

package mem_sys_pkg;

   `include "mem_sys_consts.svh"

   ////////////////////////////////////////////////////////////
   // Bus vectors
   ////////////////////////////////////////////////////////////
   typedef logic [`BUS_ADDR_W-1:0] addr_t;
   typedef logic [`BUS_DATA_W-1:0] data_t;
   // All zero strobes mean a read
   typedef logic [`BUS_STRB_W-1:0] strb_t;
   typedef logic [`LED_W-1:0] led_t;

   // Decoded from addr[31:30]
   typedef enum logic [1:0] {
      REGION_MAIN   = 2'b00,
      REGION_DDR    = 2'b01,
      REGION_STATUS = 2'b10,
      REGION_NONE   = 2'b11
   } region_t;

   // One host request, 68 bits
   typedef struct packed {
      addr_t addr;
      data_t wdata;
      strb_t wstrb;
   } bus_req_t;

endpackage

`default_nettype wire

//--- source/word_memory.sv
`timescale 1ns/1ps
`default_nettype none

module word_memory #(
   parameter int ADDR_W = 10
) (
   input  wire logic              clk,
   input  wire logic [ADDR_W-1:0] addr,
   input  mem_sys_pkg::data_t     wdata,
   input  mem_sys_pkg::strb_t     wstrb,
   input  wire logic              en,
   output mem_sys_pkg::data_t     rdata
);

   import mem_sys_pkg::*;

   localparam int DEPTH = 2 ** ADDR_W;

   // Word array
   data_t mem [DEPTH];

   ////////////////////////////////////////////////////////////
   // Byte writes
   ////////////////////////////////////////////////////////////
   always_ff @(posedge clk) begin
      if (en) begin
         for (int i = 0; i < $bits(strb_t); i++) begin
            // Unstrobed lanes keep their contents
            if (wstrb[i]) begin
               mem[addr][8*i +: 8] <= wdata[8*i +: 8];
            end
         end
      end
   end

   ////////////////////////////////////////////////////////////
   // Registered read
   ////////////////////////////////////////////////////////////
   // Old word on a write cycle, held until the next enable
   always_ff @(posedge clk) begin
      if (en) begin
         rdata <= mem[addr];
      end
   end

endmodule

`default_nettype wire

//--- source/mem_slave.sv
`timescale 1ns/1ps
`default_nettype none

module mem_slave #(
   parameter int ADDR_W  = 10,
   parameter int LATENCY = 1
) (
   input  wire logic            clk,
   input  wire logic            rst_n,
   input  wire logic            valid,
   input  mem_sys_pkg::bus_req_t req,
   output logic                 ready,
   output mem_sys_pkg::data_t   rdata
);

   import mem_sys_pkg::*;

   localparam int CNT_W = $clog2(LATENCY + 1);
   localparam logic [CNT_W-1:0] LAST_CNT = CNT_W'(LATENCY - 1);

   logic [CNT_W-1:0]  cnt;
   logic [ADDR_W-1:0] word_addr;
   logic              first;
   logic              is_read;
   data_t             mem_rdata;

   // Byte address to word index
   assign word_addr = req.addr[ADDR_W+1:2];
   assign is_read   = (req.wstrb == '0);

   // Valid is ignored in the ready cycle
   assign first = valid && !ready && (cnt == '0);

   ////////////////////////////////////////////////////////////
   // Latency counter and ready pulse
   ////////////////////////////////////////////////////////////
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         cnt   <= '0;
         ready <= 1'b0;
      end else begin
         ready <= 1'b0;
         if (valid && !ready) begin
            if (cnt == LAST_CNT) begin
               ready <= 1'b1;
               cnt   <= '0;
            end else begin
               cnt <= cnt + 1'b1;
            end
         end else begin
            // Request withdrawn, start over
            cnt <= '0;
         end
      end
   end

   // Access goes to the RAM once, on the first valid cycle
   word_memory #(
      .ADDR_W(ADDR_W)
   ) u_mem (
      .clk  (clk),
      .addr (word_addr),
      .wdata(req.wdata),
      .wstrb(req.wstrb),
      .en   (first),
      .rdata(mem_rdata)
   );

   // Zero for writes and outside the pulse
   assign rdata = (ready && is_read) ? mem_rdata : '0;

endmodule

`default_nettype wire

//--- source/bus_interconnect.sv
`timescale 1ns/1ps
`default_nettype none

`include "mem_sys_consts.svh"

module bus_interconnect (
   input  wire logic             clk,
   input  wire logic             rst_n,
   input  wire logic             host_valid,
   input  mem_sys_pkg::bus_req_t host_req,
   output logic                  host_ready,
   output mem_sys_pkg::data_t    host_rdata,
   output logic                  main_valid,
   output logic                  ddr_valid,
   output logic                  status_valid,
   input  wire logic             main_ready,
   input  wire logic             ddr_ready,
   input  wire logic             status_ready,
   input  mem_sys_pkg::data_t    main_rdata,
   input  mem_sys_pkg::data_t    ddr_rdata,
   input  mem_sys_pkg::data_t    status_rdata,
   output mem_sys_pkg::region_t  sel
);

   import mem_sys_pkg::*;

   region_t region;
   region_t last_region;
   logic    none_ready;

   ////////////////////////////////////////////////////////////
   // Address decode
   ////////////////////////////////////////////////////////////
   assign region = region_t'(host_req.addr[`REGION_HI:`REGION_LO]);

   // Valid only toward the selected slave
   assign main_valid   = host_valid && (region == REGION_MAIN);
   assign ddr_valid    = host_valid && (region == REGION_DDR);
   assign status_valid = host_valid && (region == REGION_STATUS);

   // Sel holds the last requested region while idle
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         last_region <= REGION_MAIN;
      end else if (host_valid) begin
         last_region <= region;
      end
   end

   assign sel = host_valid ? region : last_region;

   ////////////////////////////////////////////////////////////
   // Unmapped responder
   ////////////////////////////////////////////////////////////
   // One cycle ready, no back-to-back pulse
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         none_ready <= 1'b0;
      end else begin
         none_ready <= host_valid && (region == REGION_NONE) && !none_ready;
      end
   end

   ////////////////////////////////////////////////////////////
   // Response mux
   ////////////////////////////////////////////////////////////
   always_comb begin
      unique case (region)
         REGION_MAIN: begin
            host_ready = main_ready;
            host_rdata = main_rdata;
         end
         REGION_DDR: begin
            host_ready = ddr_ready;
            host_rdata = ddr_rdata;
         end
         REGION_STATUS: begin
            host_ready = status_ready;
            host_rdata = status_rdata;
         end
         default: begin
            // Unmapped reads return zero
            host_ready = none_ready;
            host_rdata = '0;
         end
      endcase
   end

endmodule

`default_nettype wire

//--- source/status_regs.sv
`timescale 1ns/1ps
`default_nettype none

module status_regs (
   input  wire logic             clk,
   input  wire logic             rst_n,
   input  wire logic             valid,
   input  mem_sys_pkg::bus_req_t req,
   input  mem_sys_pkg::region_t  sel,
   output logic                  ready,
   output mem_sys_pkg::data_t    rdata,
   output mem_sys_pkg::led_t     led
);

   import mem_sys_pkg::*;

   data_t   scratch;
   region_t last_region;
   logic    is_read;

   assign is_read = (req.wstrb == '0);

   ////////////////////////////////////////////////////////////
   // Scratch register and ready
   ////////////////////////////////////////////////////////////
   // Strobed bytes land in the scratch word
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         scratch <= '0;
         ready   <= 1'b0;
      end else begin
         ready <= valid && !ready;
         if (valid && !ready) begin
            for (int i = 0; i < $bits(strb_t); i++) begin
               if (req.wstrb[i]) begin
                  scratch[8*i +: 8] <= req.wdata[8*i +: 8];
               end
            end
         end
      end
   end

   assign rdata = (ready && is_read) ? scratch : '0;

   // Region of the latest host request
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         last_region <= REGION_MAIN;
      end else begin
         last_region <= sel;
      end
   end

   // Region on the top pair with scratch below
   assign led = {last_region, scratch[4:0]};

endmodule

`default_nettype wire

//--- source/mem_sys_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "mem_sys_consts.svh"

module mem_sys_top (
   input  wire logic             clk,
   input  wire logic             rst_n,
   input  wire logic             valid,
   input  mem_sys_pkg::bus_req_t req,
   output logic                  ready,
   output mem_sys_pkg::data_t    rdata,
   output mem_sys_pkg::led_t     led
);

   import mem_sys_pkg::*;

   logic    main_valid, ddr_valid, status_valid;
   logic    main_ready, ddr_ready, status_ready;
   data_t   main_rdata, ddr_rdata, status_rdata;
   region_t sel;

   ////////////////////////////////////////////////////////////
   // Decode and response path
   ////////////////////////////////////////////////////////////
   bus_interconnect u_ic (
      .clk         (clk),
      .rst_n       (rst_n),
      .host_valid  (valid),
      .host_req    (req),
      .host_ready  (ready),
      .host_rdata  (rdata),
      .main_valid  (main_valid),
      .ddr_valid   (ddr_valid),
      .status_valid(status_valid),
      .main_ready  (main_ready),
      .ddr_ready   (ddr_ready),
      .status_ready(status_ready),
      .main_rdata  (main_rdata),
      .ddr_rdata   (ddr_rdata),
      .status_rdata(status_rdata),
      .sel         (sel)
   );

   ////////////////////////////////////////////////////////////
   // Slaves
   ////////////////////////////////////////////////////////////
   // Fast on-chip memory
   mem_slave #(
      .ADDR_W (`MAIN_ADDR_W),
      .LATENCY(`MAIN_LATENCY)
   ) u_main (
      .clk  (clk),
      .rst_n(rst_n),
      .valid(main_valid),
      .req  (req),
      .ready(main_ready),
      .rdata(main_rdata)
   );

   // Slow DDR-style memory
   mem_slave #(
      .ADDR_W (`DDR_ADDR_W),
      .LATENCY(`DDR_LATENCY)
   ) u_ddr (
      .clk  (clk),
      .rst_n(rst_n),
      .valid(ddr_valid),
      .req  (req),
      .ready(ddr_ready),
      .rdata(ddr_rdata)
   );

   // Scratch and LEDs
   status_regs u_status (
      .clk  (clk),
      .rst_n(rst_n),
      .valid(status_valid),
      .req  (req),
      .sel  (sel),
      .ready(status_ready),
      .rdata(status_rdata),
      .led  (led)
   );

endmodule

`default_nettype wire

//--- verification/mem_sys_properties.sv
`timescale 1ns/1ps
`default_nettype none

module mem_sys_properties (
   input wire logic             clk,
   input wire logic             rst_n,
   input wire logic             valid,
   input mem_sys_pkg::bus_req_t req,
   input wire logic             ready
);

   ////////////////////////////////////////////////////////////
   // Host handshake
   ////////////////////////////////////////////////////////////
   // Ready only answers a live request
   ready_needs_valid: assert property (
      @(posedge clk) disable iff (!rst_n) ready |-> valid
   ) else $error("host ready seen without valid");

   // Request held until the slave answers
   req_held: assert property (
      @(posedge clk) disable iff (!rst_n) (valid && !ready) |=> $stable(req)
   ) else $error("host request changed while waiting for ready");

   // Single cycle pulse
   ready_pulse: assert property (
      @(posedge clk) disable iff (!rst_n) ready |=> !ready
   ) else $error("host ready held longer than one cycle");

endmodule

`default_nettype wire

//--- verification/mem_sys_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "mem_sys_consts.svh"

module mem_sys_tb;

   import mem_sys_pkg::*;

   localparam int CLK_HALF = 20;
   localparam int N_WORDS  = 8;
   localparam int WAIT_MAX = 4 * `DDR_LATENCY + 4;

   // Requests per latency class over all tests
   localparam int MAIN_REQS   = 37;
   localparam int DDR_REQS    = 12;
   localparam int ONE_REQS    = 10;
   localparam int LAT_SUM     = MAIN_REQS * `MAIN_LATENCY + DDR_REQS * `DDR_LATENCY
                                + ONE_REQS;
   localparam int CYCLE_LIMIT = 10 * LAT_SUM;

   logic     clk;
   logic     rst_n;
   logic     valid;
   bus_req_t req;
   logic     ready;
   data_t    rdata;
   led_t     led;

   int          errors;
   int          checks;
   int          cycles;
   logic [31:0] lfsr;

   // Reference model of both memories and the scratch word
   data_t main_model [int];
   data_t ddr_model [int];
   data_t scratch_model;

   // Indices that hold known data
   int main_idx [N_WORDS];
   int shared_idx;

   mem_sys_top dut (
      .clk  (clk),
      .rst_n(rst_n),
      .valid(valid),
      .req  (req),
      .ready(ready),
      .rdata(rdata),
      .led  (led)
   );

   bind mem_sys_top mem_sys_properties u_props (
      .clk  (clk),
      .rst_n(rst_n),
      .valid(valid),
      .req  (req),
      .ready(ready)
   );

   initial begin
      clk = 1'b0;
      forever #CLK_HALF clk = ~clk;
   end

   // Watchdog
   initial begin
      cycles = 0;
      while (cycles < CYCLE_LIMIT) begin
         @(posedge clk);
         cycles++;
      end
      $display("Timeout: the run did not end within %0d cycles", CYCLE_LIMIT);
      $display("TEST FAIL");
      $finish;
   end

   ////////////////////////////////////////////////////////////
   // Stimulus helpers
   ////////////////////////////////////////////////////////////
   // Galois form of x^32+x^22+x^2+x+1
   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
   endfunction

   // One LFSR step per bit
   function automatic logic [31:0] take_bits(input int n);
      logic [31:0] bits;
      bits = '0;
      for (int i = 0; i < n; i++) begin
         bits = {bits[30:0], lfsr[0]};
         lfsr = lfsr_next(lfsr);
      end
      return bits;
   endfunction

   function automatic addr_t make_addr(input region_t r, input int idx);
      return {r, 28'(idx), 2'b00};
   endfunction

   // Top two address bits pick the region
   function automatic region_t region_of(input addr_t a);
      return region_t'(a[31:30]);
   endfunction

   function automatic int expected_latency(input region_t r);
      case (r)
         REGION_MAIN: return `MAIN_LATENCY;
         REGION_DDR:  return `DDR_LATENCY;
         default:     return 1;
      endcase
   endfunction

   ////////////////////////////////////////////////////////////
   // Reference model
   ////////////////////////////////////////////////////////////
   function automatic data_t merge_bytes(input data_t old, input data_t wd, input strb_t s);
      data_t res;
      res = old;
      for (int i = 0; i < $bits(strb_t); i++) begin
         if (s[i]) begin
            res[8*i +: 8] = wd[8*i +: 8];
         end
      end
      return res;
   endfunction

   function automatic data_t model_read(input addr_t a);
      case (region_of(a))
         REGION_MAIN:   return main_model[int'(a[`MAIN_ADDR_W+1:2])];
         REGION_DDR:    return ddr_model[int'(a[`DDR_ADDR_W+1:2])];
         REGION_STATUS: return scratch_model;
         default:       return '0;
      endcase
   endfunction

   // Unmapped writes leave everything alone
   function automatic void model_write(input bus_req_t r);
      int    k;
      data_t old;
      case (region_of(r.addr))
         REGION_MAIN: begin
            k   = int'(r.addr[`MAIN_ADDR_W+1:2]);
            old = main_model.exists(k) ? main_model[k] : '0;
            main_model[k] = merge_bytes(old, r.wdata, r.wstrb);
         end
         REGION_DDR: begin
            k   = int'(r.addr[`DDR_ADDR_W+1:2]);
            old = ddr_model.exists(k) ? ddr_model[k] : '0;
            ddr_model[k] = merge_bytes(old, r.wdata, r.wstrb);
         end
         REGION_STATUS: begin
            scratch_model = merge_bytes(scratch_model, r.wdata, r.wstrb);
         end
         default: begin
         end
      endcase
   endfunction

   ////////////////////////////////////////////////////////////
   // Compare tasks
   ////////////////////////////////////////////////////////////
   task automatic check_data(input string what, input data_t got, input data_t exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("Error at %0d ns: %s is %h, expected %h", $time, what, got, exp);
      end
   endtask

   task automatic check_led(input string what, input led_t got, input led_t exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("Error at %0d ns: %s is %b, expected %b", $time, what, got, exp);
      end
   endtask

   task automatic check_latency(input string what, input int got, input int exp);
      checks++;
      if (got != exp) begin
         errors++;
         $display("Error at %0d ns: %s is %0d cycles, expected %0d", $time, what, got, exp);
      end
   endtask

   ////////////////////////////////////////////////////////////
   // Bus driver
   ////////////////////////////////////////////////////////////
   // Drive on the edge and count edges until ready
   task automatic issue(input bus_req_t r, output data_t got, output int lat);
      @(posedge clk);
      valid <= 1'b1;
      req   <= r;
      lat = 0;
      do begin
         @(negedge clk);
         if (!ready) begin
            lat++;
         end
      end while (!ready && lat <= WAIT_MAX);
      got = rdata;
   endtask

   task automatic idle();
      @(posedge clk);
      valid <= 1'b0;
      @(negedge clk);
   endtask

   // One checked request with hold keeping valid up for the next one
   task automatic access(input addr_t a, input data_t d, input strb_t s, input bit hold);
      bus_req_t r;
      data_t    got;
      data_t    exp;
      int       lat;
      r.addr  = a;
      r.wdata = d;
      r.wstrb = s;
      // Writes answer with zero
      exp = (s == '0) ? model_read(a) : '0;
      issue(r, got, lat);
      if (!ready) begin
         errors++;
         $display("The DUT gave no ready for the request to address %h", a);
      end else begin
         check_latency($sformatf("latency at %h", a), lat, expected_latency(region_of(a)));
         check_data($sformatf("rdata at %h", a), got, exp);
      end
      if (s != '0) begin
         model_write(r);
      end
      if (!hold) begin
         idle();
      end
   endtask

   task automatic finish_test(input string name, input int err0);
      $display("%-22s %s (%0d errors)", name, (errors == err0) ? "passed" : "failed",
               errors - err0);
   endtask

   ////////////////////////////////////////////////////////////
   // Tests
   ////////////////////////////////////////////////////////////
   task automatic reset_dut();
      int err0;
      err0 = errors;
      rst_n <= 1'b0;
      repeat (4) @(posedge clk);
      rst_n <= 1'b1;
      @(negedge clk);
      // All LEDs dark out of reset
      check_led("led after reset", led, '0);
      finish_test("reset", err0);
   endtask

   task automatic test_main_rw();
      int err0;
      err0 = errors;
      for (int i = 0; i < N_WORDS; i++) begin
         main_idx[i] = int'(take_bits(`MAIN_ADDR_W));
         access(make_addr(REGION_MAIN, main_idx[i]), take_bits(32), 4'hf, 1'b0);
      end
      for (int i = 0; i < N_WORDS; i++) begin
         access(make_addr(REGION_MAIN, main_idx[i]), '0, '0, 1'b0);
      end
      finish_test("main write and read", err0);
   endtask

   task automatic test_partial_strobe();
      int    err0;
      int    idx;
      strb_t patterns [4];
      err0 = errors;
      patterns = '{4'b0001, 4'b0110, 4'b1000, 4'b1010};
      idx = int'(take_bits(`MAIN_ADDR_W));
      // Full word first so every byte is known
      access(make_addr(REGION_MAIN, idx), take_bits(32), 4'hf, 1'b0);
      foreach (patterns[i]) begin
         access(make_addr(REGION_MAIN, idx), take_bits(32), patterns[i], 1'b0);
         access(make_addr(REGION_MAIN, idx), '0, '0, 1'b0);
      end
      finish_test("partial strobes", err0);
   endtask

   task automatic test_ddr();
      int err0;
      err0 = errors;
      for (int i = 0; i < 4; i++) begin
         // Same word index in both memories
         shared_idx = int'(take_bits(`DDR_ADDR_W));
         access(make_addr(REGION_MAIN, shared_idx), take_bits(32), 4'hf, 1'b0);
         access(make_addr(REGION_DDR, shared_idx), take_bits(32), 4'hf, 1'b0);
         access(make_addr(REGION_DDR, shared_idx), '0, '0, 1'b0);
         access(make_addr(REGION_MAIN, shared_idx), '0, '0, 1'b0);
      end
      finish_test("ddr region", err0);
   endtask

   task automatic test_status_led();
      int      err0;
      region_t order [4];
      err0 = errors;
      order = '{REGION_MAIN, REGION_DDR, REGION_STATUS, REGION_NONE};
      access(make_addr(REGION_STATUS, 0), take_bits(32), 4'hf, 1'b0);
      access(make_addr(REGION_STATUS, 0), '0, '0, 1'b0);
      check_led("led after scratch", led, {REGION_STATUS, scratch_model[4:0]});
      // Region code follows the last access
      foreach (order[i]) begin
         access(make_addr(order[i], shared_idx), '0, '0, 1'b0);
         check_led($sformatf("led after region %0d", order[i]), led,
                   {order[i], scratch_model[4:0]});
      end
      finish_test("status and leds", err0);
   endtask

   task automatic test_unmapped();
      int err0;
      err0 = errors;
      access(make_addr(REGION_NONE, shared_idx), '0, '0, 1'b0);
      access(make_addr(REGION_NONE, shared_idx), take_bits(32), 4'hf, 1'b0);
      // Same low bits still hold the old data
      access(make_addr(REGION_MAIN, shared_idx), '0, '0, 1'b0);
      access(make_addr(REGION_DDR, shared_idx), '0, '0, 1'b0);
      access(make_addr(REGION_STATUS, 0), '0, '0, 1'b0);
      finish_test("unmapped region", err0);
   endtask

   task automatic test_back_to_back();
      int err0;
      err0 = errors;
      // Valid stays high across every ready
      access(make_addr(REGION_MAIN, main_idx[0]), take_bits(32), 4'hf, 1'b1);
      access(make_addr(REGION_DDR, shared_idx), take_bits(32), 4'hf, 1'b1);
      access(make_addr(REGION_MAIN, main_idx[0]), '0, '0, 1'b1);
      access(make_addr(REGION_DDR, shared_idx), '0, '0, 1'b1);
      access(make_addr(REGION_STATUS, 0), take_bits(32), 4'b0011, 1'b1);
      access(make_addr(REGION_STATUS, 0), '0, '0, 1'b1);
      access(make_addr(REGION_NONE, 0), '0, '0, 1'b0);
      finish_test("back to back", err0);
   endtask

   ////////////////////////////////////////////////////////////
   // Main sequence
   ////////////////////////////////////////////////////////////
   initial begin
      errors        = 0;
      checks        = 0;
      lfsr          = 32'h122e_f59e;
      scratch_model = '0;
      rst_n         = 1'b0;
      valid         = 1'b0;
      req           = '0;
      reset_dut();
      test_main_rw();
      test_partial_strobe();
      test_ddr();
      test_status_led();
      test_unmapped();
      test_back_to_back();
      $display("Checks: %0d, errors: %0d", checks, errors);
      if (errors == 0) begin
         $display("TEST PASS");
      end else begin
         $display("TEST FAIL");
      end
      $finish;
   end

endmodule

`default_nettype wire

//--- mem_sys.f
+incdir+source
source/mem_sys_pkg.sv
source/word_memory.sv
source/mem_slave.sv
source/bus_interconnect.sv
source/status_regs.sv
source/mem_sys_top.sv
verification/mem_sys_properties.sv
verification/mem_sys_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= mem_sys_tb
FILELIST  ?= mem_sys.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: sim clean

# Build, run, and pass only when the testbench prints its pass line
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TEST PASS"

clean:
	rm -rf $(OBJ_DIR)
